// File: logic/integraB_params.svh
`ifndef INTEGRAB_PARAMS_SVH
`define INTEGRAB_PARAMS_SVH

// Host bus widths of the 6502 side
`define INTEGRA_ADDR_W 16
`define INTEGRA_DATA_W 8

// Sideways ROM/RAM banks and the width of the bank latch
`define INTEGRA_BANKS 16
`define INTEGRA_BANK_W 4

// Upper 12 address bits of the &FE3x register page
`define INTEGRA_IO_PAGE 12'hFE3

// RAM address lines A14..A18 switched by the board
`define INTEGRA_RAM_HI_W 5

// A15..A14 of the sideways window &8000..&BFFF
`define INTEGRA_SW_WINDOW 2'b10

// Screen memory is &3000..&3FFF plus &4000..&7FFF
`define INTEGRA_SCREEN_LO 4'h3
`define INTEGRA_SCREEN_HI 2'b01

// Top nibbles of the private RAM areas at &8xxx, &9xxx and &Axxx
`define INTEGRA_PRIV_LO 4'h8
`define INTEGRA_PRIV_MID 4'h9
`define INTEGRA_PRIV_HI 4'hA

`endif

// File: logic/integraPkg.sv
package integraPkg;

	// Decoded register access within the &FE3x page
	// Address bits A0 and A1 are ignored so several addresses share one register
	// &FE39 has no register behind it and decodes to regNone
	typedef enum logic [2:0] {
		regNone,
		// &FE30..&FE33 holds the bank latch, private enable and memSel
		regRomLatch,
		// &FE34..&FE37 holds the private RAM sizes and the shadow enable
		regPrivCtl,
		// &FE38 latches an RTC address
		regRtcAddr,
		// Write enables of banks 0..7
		regWpLow,
		// Write enables of banks 8..15
		regWpHigh,
		// &FE3C..&FE3F is the RTC data window
		regRtcData
	} regSelT;

	// What the current host access lands on
	typedef enum logic [2:0] {
		tgtNone,
		// Motherboard ROM in banks 0..3
		tgtBeebRom,
		// One of the on-board ROM sockets in banks 8..15
		tgtIntegraRom,
		// A 16K sideways RAM bank on the board
		tgtSwRam,
		// The 32K block shared by screen shadow and private RAM
		tgtShadow
	} memTargetT;

endpackage

// File: logic/ioAddressDecoder.sv
`timescale 1ns/10ps
`include "integraB_params.svh"

module ioAddressDecoder
	import integraPkg::*;
(
	input  logic [`INTEGRA_ADDR_W-1:0] cpuAddress,
	input  logic                       cpuRnW,
	input  logic                       cpuPhi2,
	output regSelT                     regSel,
	output logic                       ioPage,
	output logic                       rtcAs,
	output logic                       rtcDs
);

	// High for any address in &FE30..&FE3F whatever the bus phase
	assign ioPage = (cpuAddress[`INTEGRA_ADDR_W-1:4] == `INTEGRA_IO_PAGE);

	// Low nibble picks the register
	// Groups of four are matched on A3..A2 alone
	always_comb begin
		regSel = regNone;
		if (ioPage) begin
			case (cpuAddress[3:2])
				2'b00: regSel = regRomLatch;
				2'b01: regSel = regPrivCtl;
				2'b11: regSel = regRtcData;
				default: begin
					// Single registers in &FE38..&FE3B need the full nibble
					case (cpuAddress[1:0])
						2'b00: regSel = regRtcAddr;
						2'b10: regSel = regWpLow;
						2'b11: regSel = regWpHigh;
						default: regSel = regNone;
					endcase
				end
			endcase
		end
	end

	// The RTC latches its address on a write strobe to &FE38
	assign rtcAs = (regSel == regRtcAddr) && cpuPhi2 && !cpuRnW;

	// Data strobe covers reads and writes to &FE3C..&FE3F
	assign rtcDs = (regSel == regRtcData) && cpuPhi2;

endmodule

// File: logic/pagingRegisters.sv
`timescale 1ns/10ps
`include "integraB_params.svh"

module pagingRegisters
	import integraPkg::*;
(
	input  logic                       ccA14_clk,
	input  logic                       bbc_nRST,
	input  logic                       cpuRnW,
	input  logic                       cpuPhi2,
	input  logic [`INTEGRA_DATA_W-1:0] cpuData,
	input  regSelT                     regSel,
	output logic [`INTEGRA_BANK_W-1:0] romLatch,
	output logic                       privEn,
	output logic                       memSel,
	output logic                       privS8,
	output logic                       privS4,
	output logic                       privS1,
	output logic                       shEn,
	output logic [`INTEGRA_BANKS-1:0]  wpEnable
);

	// Upper half of the write enables sits behind the second register
	localparam int WpHalf = `INTEGRA_BANKS / 2;

	// A host write is valid while Phi2 is high and RnW is low
	logic hostWrite;

	assign hostWrite = cpuPhi2 && !cpuRnW;

	// Every flag comes up clear so only bank 0 is paged in
	// All RAM banks start write protected
	always_ff @(posedge ccA14_clk) begin
		if (!bbc_nRST) begin
			romLatch <= '0;
			privEn   <= 1'b0;
			memSel   <= 1'b0;
			privS8   <= 1'b0;
			privS4   <= 1'b0;
			privS1   <= 1'b0;
			shEn     <= 1'b0;
			wpEnable <= '0;
		end else if (hostWrite) begin
			case (regSel)
				regRomLatch: begin
					// Bank number in D0..D3
					romLatch <= cpuData[`INTEGRA_BANK_W-1:0];
					// D6 turns private RAM on
					privEn   <= cpuData[6];
					// D7 lets the CPU see main memory under the shadow screen
					memSel   <= cpuData[7];
				end
				regPrivCtl: begin
					// Private area sizes of 8K, 4K and 1K in D4..D6
					privS8 <= cpuData[4];
					privS4 <= cpuData[5];
					privS1 <= cpuData[6];
					// D7 moves the screen into shadow RAM
					shEn   <= cpuData[7];
				end
				// A set bit allows writes to that RAM bank
				regWpLow: wpEnable[WpHalf-1:0] <= cpuData;
				regWpHigh: wpEnable[`INTEGRA_BANKS-1:WpHalf] <= cpuData;
				// RTC accesses and unused addresses leave the registers alone
				default: begin
				end
			endcase
		end
	end

endmodule

// File: logic/shadowMapper.sv
`timescale 1ns/10ps
`include "integraB_params.svh"

module shadowMapper (
	input  logic [`INTEGRA_ADDR_W-1:0] cpuAddress,
	input  logic                       cpuRnW,
	input  logic                       cpuPhi1,
	input  logic                       shEn,
	input  logic                       memSel,
	input  logic                       privEn,
	input  logic                       privS1,
	input  logic                       privS4,
	input  logic                       privS8,
	output logic                       shAct,
	output logic                       privAct,
	output logic                       shadowSel,
	output logic                       toBbcPhi1,
	output logic                       toBbcRnW
);

	// Top address nibble is enough for most of the map
	logic [3:0] addrTop;
	logic       screenMem;

	assign addrTop = cpuAddress[`INTEGRA_ADDR_W-1:`INTEGRA_ADDR_W-4];

	// Screen memory spans &3000..&7FFF
	assign screenMem = (addrTop == `INTEGRA_SCREEN_LO)
		|| (cpuAddress[`INTEGRA_ADDR_W-1:`INTEGRA_ADDR_W-2] == `INTEGRA_SCREEN_HI);

	// memSel hands the screen area back to main memory for the CPU
	assign shAct = screenMem && shEn && !memSel;

	// 1K area &8000..&83FF, 4K area &8000..&8FFF and 8K area &9000..&AFFF
	// These sit at &0000..&2FFF of the 32K block below the screen copy
	assign privAct = privEn && (
		((addrTop == `INTEGRA_PRIV_LO) && (cpuAddress[11:10] == 2'b00) && privS1)
		|| ((addrTop == `INTEGRA_PRIV_LO) && privS4)
		|| (((addrTop == `INTEGRA_PRIV_MID) || (addrTop == `INTEGRA_PRIV_HI)) && privS8));

	// Either kind of access uses the 32K block
	assign shadowSel = shAct || privAct;

	// Holding Phi1 and RnW high hides shadow accesses from main memory
	assign toBbcPhi1 = cpuPhi1 || shAct;
	assign toBbcRnW  = cpuRnW || shAct;

endmodule

// File: logic/memorySelect.sv
`timescale 1ns/10ps
`include "integraB_params.svh"

module memorySelect
	import integraPkg::*;
(
	input  logic [`INTEGRA_ADDR_W-1:0]        cpuAddress,
	input  logic                              cpuRnW,
	input  logic                              cpuPhi2,
	input  logic [`INTEGRA_BANK_W-1:0]        romLatch,
	input  logic [`INTEGRA_BANKS-1:0]         wpEnable,
	input  logic [3:0]                        beebRomSel,
	input  logic [`INTEGRA_BANKS-1:`INTEGRA_BANKS/2] integraRomSel,
	input  logic                              privAct,
	input  logic                              shadowSel,
	input  logic                              ioPage,
	output logic                              nRomBankSel0to3,
	output logic [`INTEGRA_BANKS-1:`INTEGRA_BANKS/2] nRomBankSel,
	output logic                              nRamCe,
	output logic [`INTEGRA_RAM_HI_W-1:0]      ramAddress,
	output logic                              nRds,
	output logic                              nWds,
	output logic                              nDBufCe,
	output logic                              nDBufDir
);

	logic      swAddr;
	logic      romDec;
	logic      writeAllowed;
	memTargetT target;

	// Sideways window is &8000..&BFFF
	assign swAddr = (cpuAddress[`INTEGRA_ADDR_W-1:`INTEGRA_ADDR_W-2] == `INTEGRA_SW_WINDOW);

	// Private RAM takes precedence over the paged bank
	assign romDec = swAddr && !privAct && cpuPhi2;

	// Name what this access hits
	// Nothing is selected outside Phi2 so all chip enables stay idle
	always_comb begin
		target = tgtNone;
		if (cpuPhi2 && shadowSel) begin
			target = tgtShadow;
		end else if (romDec) begin
			if ((romLatch[3:2] == 2'b00) && beebRomSel[romLatch[1:0]]) begin
				// Jumper keeps this bank on the motherboard
				target = tgtBeebRom;
			end else if (romLatch[3] && integraRomSel[{1'b1, romLatch[2:0]}]) begin
				// Jumper puts a socket ROM in this bank
				target = tgtIntegraRom;
			end else begin
				// Every other bank is on-board RAM
				target = tgtSwRam;
			end
		end
	end

	// Motherboard ROM select is shared by banks 0..3
	assign nRomBankSel0to3 = (target != tgtBeebRom);

	// Socket ROM selects are open drain and only ever pull low
	for (genvar i = `INTEGRA_BANKS / 2; i < `INTEGRA_BANKS; i++) begin : gSocket
		assign nRomBankSel[i] = ((target == tgtIntegraRom) && (romLatch == i)) ? 1'b0 : 1'bz;
	end

	// One RAM chip holds the 16 banks and the 32K shadow block
	assign nRamCe = !((target == tgtSwRam) || (target == tgtShadow));

	// Banks fill the lower 256K of the chip
	// The shadow block sits above them with A14 taken from the host
	always_comb begin
		case (target)
			tgtSwRam:  ramAddress = {1'b0, romLatch};
			tgtShadow: ramAddress = {1'b1, 3'b000, cpuAddress[14]};
			default:   ramAddress = '0;
		endcase
	end

	// Read strobe follows the bus for every read
	assign nRds = !(cpuRnW && cpuPhi2);

	// Protection only applies to RAM banks
	// Socket ROM writes pass through so EEPROMs can be programmed in place
	assign writeAllowed = ((target == tgtSwRam) && wpEnable[romLatch])
		|| (target == tgtIntegraRom)
		|| (target == tgtShadow);

	assign nWds = !(!cpuRnW && cpuPhi2 && writeAllowed);

	// Buffer points at the board for writes and at the host for reads
	assign nDBufDir = cpuRnW;

	// Buffer is on for anything the board answers and off for motherboard ROM
	assign nDBufCe = !(ioPage
		|| (target == tgtSwRam)
		|| (target == tgtIntegraRom)
		|| (target == tgtShadow));

endmodule

// File: logic/integraB.sv
`timescale 1ns/10ps
`include "integraB_params.svh"

module integraB
	import integraPkg::*;
(
	input  logic                              ccA14_clk,
	input  logic                              bbc_nRST,
	input  logic                              cpuRnW,
	input  logic                              cpuPhi1,
	input  logic [`INTEGRA_ADDR_W-1:0]        cpuAddress,
	input  logic [`INTEGRA_DATA_W-1:0]        cpuData,
	input  logic [3:0]                        beebRomSel,
	input  logic [`INTEGRA_BANKS-1:`INTEGRA_BANKS/2] integraRomSel,
	output logic                              toBbcPhi1,
	output logic                              toBbcRnW,
	output logic [`INTEGRA_BANK_W-1:0]        romLatch,
	output logic                              nDBufCe,
	output logic                              nDBufDir,
	output logic                              nWds,
	output logic                              nRds,
	output logic                              nRomBankSel0to3,
	output logic [`INTEGRA_BANKS-1:`INTEGRA_BANKS/2] nRomBankSel,
	output logic                              rtcAs,
	output logic                              rtcDs,
	output logic                              nRamCe,
	output logic [`INTEGRA_RAM_HI_W-1:0]      ramAddress
);

	logic                      cpuPhi2;
	regSelT                    regSel;
	logic                      ioPage;
	logic                      privEn;
	logic                      memSel;
	logic                      privS8;
	logic                      privS4;
	logic                      privS1;
	logic                      shEn;
	logic [`INTEGRA_BANKS-1:0] wpEnable;
	logic                      privAct;
	logic                      shadowSel;

	// Only Phi1 reaches the board so Phi2 is rebuilt here
	assign cpuPhi2 = !cpuPhi1;

	ioAddressDecoder i_ioDecoder (
		.cpuAddress(cpuAddress),
		.cpuRnW    (cpuRnW),
		.cpuPhi2   (cpuPhi2),
		.regSel    (regSel),
		.ioPage    (ioPage),
		.rtcAs     (rtcAs),
		.rtcDs     (rtcDs)
	);

	pagingRegisters i_regs (
		.ccA14_clk(ccA14_clk),
		.bbc_nRST (bbc_nRST),
		.cpuRnW   (cpuRnW),
		.cpuPhi2  (cpuPhi2),
		.cpuData  (cpuData),
		.regSel   (regSel),
		.romLatch (romLatch),
		.privEn   (privEn),
		.memSel   (memSel),
		.privS8   (privS8),
		.privS4   (privS4),
		.privS1   (privS1),
		.shEn     (shEn),
		.wpEnable (wpEnable)
	);

	// Screen shadow only shows at the board edge through the repeated Phi1 and RnW
	shadowMapper i_shadow (
		.cpuAddress(cpuAddress),
		.cpuRnW    (cpuRnW),
		.cpuPhi1   (cpuPhi1),
		.shEn      (shEn),
		.memSel    (memSel),
		.privEn    (privEn),
		.privS1    (privS1),
		.privS4    (privS4),
		.privS8    (privS8),
		.shAct     (),
		.privAct   (privAct),
		.shadowSel (shadowSel),
		.toBbcPhi1 (toBbcPhi1),
		.toBbcRnW  (toBbcRnW)
	);

	memorySelect i_memSel (
		.cpuAddress     (cpuAddress),
		.cpuRnW         (cpuRnW),
		.cpuPhi2        (cpuPhi2),
		.romLatch       (romLatch),
		.wpEnable       (wpEnable),
		.beebRomSel     (beebRomSel),
		.integraRomSel  (integraRomSel),
		.privAct        (privAct),
		.shadowSel      (shadowSel),
		.ioPage         (ioPage),
		.nRomBankSel0to3(nRomBankSel0to3),
		.nRomBankSel    (nRomBankSel),
		.nRamCe         (nRamCe),
		.ramAddress     (ramAddress),
		.nRds           (nRds),
		.nWds           (nWds),
		.nDBufCe        (nDBufCe),
		.nDBufDir       (nDBufDir)
	);

endmodule

// File: testbench/integraBVectors.svh
`ifndef INTEGRABVECTORS_SVH
`define INTEGRABVECTORS_SVH

// A write entry performs one register write and is followed by an idle cycle
// A check entry holds a bus access and compares the outputs in the same cycle
typedef enum logic {
	vecWrite,
	vecCheck
} vecKindT;

typedef struct packed {
	vecKindT                        kind;
	logic [`INTEGRA_ADDR_W-1:0]     addr;
	logic [`INTEGRA_DATA_W-1:0]     data;
	// Bus phase as {RnW, Phi1}
	logic [1:0]                     bus;
	logic [3:0]                     beebSel;
	// Socket jumpers for banks 15..8
	logic [7:0]                     integSel;
	memTargetT                      target;
	logic [`INTEGRA_BANK_W-1:0]     latch;
	logic [`INTEGRA_RAM_HI_W-1:0]   ramAddr;
	// Expected {nRds, nWds, nDBufCe, toBbcPhi1, toBbcRnW, rtcAs, rtcDs}
	logic [6:0]                     flags;
} vectorT;

localparam int NumVecs = 25;

// Columns are kind, address, data, {RnW, Phi1}, beebRomSel, integraRomSel,
// then the expected target, romLatch, ramAddress and strobe flags
localparam vectorT vecTable [NumVecs] = '{
	// Reset state with bank 0 on the motherboard, then as a protected RAM bank
	'{vecCheck, 16'h8000, 8'h00, 2'b10, 4'h1, 8'h00, tgtBeebRom, 4'h0, 5'h00, 7'b0110100},
	'{vecCheck, 16'h8000, 8'h00, 2'b10, 4'h0, 8'h00, tgtSwRam, 4'h0, 5'h00, 7'b0100100},
	'{vecCheck, 16'h8000, 8'h5A, 2'b00, 4'h0, 8'h00, tgtSwRam, 4'h0, 5'h00, 7'b1100000},
	// Bank 9 as a socket ROM and then as RAM
	'{vecWrite, 16'hFE30, 8'h09, 2'b00, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b0000000},
	'{vecCheck, 16'h9000, 8'h00, 2'b10, 4'h0, 8'h02, tgtIntegraRom, 4'h9, 5'h00, 7'b0100100},
	'{vecCheck, 16'h9000, 8'h00, 2'b10, 4'h0, 8'h00, tgtSwRam, 4'h9, 5'h09, 7'b0100100},
	// Write enables on for bank 5 and then bank 5 protected again
	'{vecWrite, 16'hFE3A, 8'hFF, 2'b00, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b0000000},
	'{vecWrite, 16'hFE31, 8'h05, 2'b00, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b0000000},
	'{vecCheck, 16'hA000, 8'h33, 2'b00, 4'h0, 8'h00, tgtSwRam, 4'h5, 5'h05, 7'b1000000},
	'{vecWrite, 16'hFE3A, 8'hDF, 2'b00, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b0000000},
	'{vecCheck, 16'hA000, 8'h33, 2'b00, 4'h0, 8'h00, tgtSwRam, 4'h5, 5'h05, 7'b1100000},
	// Screen shadow on with host A14 in bit 0 of the RAM address
	'{vecWrite, 16'hFE34, 8'h80, 2'b00, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b0000000},
	'{vecCheck, 16'h4000, 8'h00, 2'b10, 4'h0, 8'h00, tgtShadow, 4'h5, 5'h11, 7'b0101100},
	'{vecCheck, 16'h3000, 8'hC3, 2'b00, 4'h0, 8'h00, tgtShadow, 4'h5, 5'h10, 7'b1001100},
	// memSel hands the screen area back to main memory
	'{vecWrite, 16'hFE30, 8'h80, 2'b00, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b0000000},
	'{vecCheck, 16'h4000, 8'h00, 2'b10, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b0110100},
	// Private 1K area at &8000..&83FF
	'{vecWrite, 16'hFE30, 8'h40, 2'b00, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b0000000},
	'{vecWrite, 16'hFE37, 8'h40, 2'b00, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b0000000},
	'{vecCheck, 16'h8200, 8'h00, 2'b10, 4'h1, 8'h00, tgtShadow, 4'h0, 5'h10, 7'b0100100},
	'{vecCheck, 16'h8800, 8'h00, 2'b10, 4'h1, 8'h00, tgtBeebRom, 4'h0, 5'h00, 7'b0110100},
	// RTC strobes with Phi2 high, then with Phi2 low
	'{vecCheck, 16'hFE38, 8'h0C, 2'b00, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b1100010},
	'{vecCheck, 16'hFE3D, 8'h00, 2'b10, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b0100101},
	'{vecCheck, 16'hFE3D, 8'h00, 2'b11, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b1101100},
	'{vecCheck, 16'hFE38, 8'h0C, 2'b01, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b1101000},
	// Phi1 high leaves every select idle
	'{vecCheck, 16'h8000, 8'h00, 2'b11, 4'h0, 8'h00, tgtNone, 4'h0, 5'h00, 7'b1111100}
};

`endif

// File: testbench/integraBTb.sv
`timescale 1ns/10ps
`include "integraB_params.svh"

module integraBTb
	import integraPkg::*;
();

	logic                              ccA14_clk = 1'b0;
	logic                              bbc_nRST;
	logic                              cpuRnW;
	logic                              cpuPhi1;
	logic [`INTEGRA_ADDR_W-1:0]        cpuAddress;
	logic [`INTEGRA_DATA_W-1:0]        cpuData;
	logic [3:0]                        beebRomSel;
	logic [`INTEGRA_BANKS-1:`INTEGRA_BANKS/2] integraRomSel;
	logic                              toBbcPhi1;
	logic                              toBbcRnW;
	logic [`INTEGRA_BANK_W-1:0]        romLatch;
	logic                              nDBufCe;
	logic                              nDBufDir;
	logic                              nWds;
	logic                              nRds;
	logic                              nRomBankSel0to3;
	wire  [`INTEGRA_BANKS-1:`INTEGRA_BANKS/2] nRomBankSel;
	logic                              rtcAs;
	logic                              rtcDs;
	logic                              nRamCe;
	logic [`INTEGRA_RAM_HI_W-1:0]      ramAddress;

`include "integraBVectors.svh"

	// Each entry takes at most two cycles and the margin covers reset
	localparam int CycleLimit = NumVecs * 3 + 20;

	int cycleCount = 0;

	integraB i_dut (
		.ccA14_clk      (ccA14_clk),
		.bbc_nRST       (bbc_nRST),
		.cpuRnW         (cpuRnW),
		.cpuPhi1        (cpuPhi1),
		.cpuAddress     (cpuAddress),
		.cpuData        (cpuData),
		.beebRomSel     (beebRomSel),
		.integraRomSel  (integraRomSel),
		.toBbcPhi1      (toBbcPhi1),
		.toBbcRnW       (toBbcRnW),
		.romLatch       (romLatch),
		.nDBufCe        (nDBufCe),
		.nDBufDir       (nDBufDir),
		.nWds           (nWds),
		.nRds           (nRds),
		.nRomBankSel0to3(nRomBankSel0to3),
		.nRomBankSel    (nRomBankSel),
		.rtcAs          (rtcAs),
		.rtcDs          (rtcDs),
		.nRamCe         (nRamCe),
		.ramAddress     (ramAddress)
	);

	// 4 ns period
	always #2 ccA14_clk = ~ccA14_clk;

	always @(posedge ccA14_clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("Timeout: the table did not complete within %0d cycles", CycleLimit);
			$display("Finished with errors");
			$fatal(1, "Run stopped by timeout");
		end
	end

	// Case equality so an undriven open-drain line must really be z
	task automatic compareValue(input logic [15:0] actual, input logic [15:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("error at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
			$display("Finished with errors");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic driveBus(input vectorT v);
		cpuAddress    = v.addr;
		cpuData       = v.data;
		cpuRnW        = v.bus[1];
		cpuPhi1       = v.bus[0];
		beebRomSel    = v.beebSel;
		integraRomSel = v.integSel;
	endtask

	// The write lands on the next edge and the bus then goes idle for a cycle
	task automatic writeRegister(input vectorT v);
		driveBus(v);
		@(posedge ccA14_clk);
		#1;
		cpuRnW  = 1'b1;
		cpuPhi1 = 1'b1;
	endtask

	task automatic verifyOutputs(input int idx, input vectorT v);
		logic [7:0] expSocket;
		logic       expRamCe;
		string      tag;
		int         i;
		tag = $sformatf("entry %0d", idx);
		// Only the socket of the paged bank pulls low and every other line floats
		for (i = 0; i < 8; i++) begin
			expSocket[i] = ((v.target == tgtIntegraRom) && (v.latch == i + 8)) ? 1'b0 : 1'bz;
		end
		// The RAM chip holds both the sideways banks and the 32K shadow block
		expRamCe = !((v.target == tgtSwRam) || (v.target == tgtShadow));
		compareValue(romLatch, v.latch, {tag, " romLatch"});
		compareValue(nRamCe, expRamCe, {tag, " nRamCe"});
		compareValue(nRomBankSel0to3, v.target != tgtBeebRom, {tag, " nRomBankSel0to3"});
		compareValue(nRomBankSel, expSocket, {tag, " nRomBankSel"});
		compareValue(ramAddress, v.ramAddr, {tag, " ramAddress"});
		compareValue(nRds, v.flags[6], {tag, " nRds"});
		compareValue(nWds, v.flags[5], {tag, " nWds"});
		compareValue(nDBufCe, v.flags[4], {tag, " nDBufCe"});
		compareValue(toBbcPhi1, v.flags[3], {tag, " toBbcPhi1"});
		compareValue(toBbcRnW, v.flags[2], {tag, " toBbcRnW"});
		compareValue(rtcAs, v.flags[1], {tag, " rtcAs"});
		compareValue(rtcDs, v.flags[0], {tag, " rtcDs"});
		// Buffer direction simply follows RnW
		compareValue(nDBufDir, v.bus[1], {tag, " nDBufDir"});
	endtask

	initial begin
		int idx;
		// Bus starts idle in Phi1 with the board held in reset
		bbc_nRST      = 1'b0;
		cpuRnW        = 1'b1;
		cpuPhi1       = 1'b1;
		cpuAddress    = '0;
		cpuData       = '0;
		beebRomSel    = '0;
		integraRomSel = '0;
		repeat (3) @(posedge ccA14_clk);
		#1;
		bbc_nRST = 1'b1;
		for (idx = 0; idx < NumVecs; idx++) begin
			@(posedge ccA14_clk);
			#1;
			if (vecTable[idx].kind == vecWrite) begin
				writeRegister(vecTable[idx]);
			end else begin
				driveBus(vecTable[idx]);
				// Outputs settle well before the next edge
				#2;
				verifyOutputs(idx, vecTable[idx]);
			end
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: all.f
+incdir+logic
+incdir+testbench
logic/integraPkg.sv
logic/ioAddressDecoder.sv
logic/pagingRegisters.sv
logic/shadowMapper.sv
logic/memorySelect.sv
logic/integraB.sv
testbench/integraBTb.sv
